/* compile.f */
+incdir+rtl
rtl/pkg_mpu.sv
rtl/host_if_mpu.sv
rtl/thread_mem_mpu.sv
rtl/map_table_mpu.sv
rtl/dispatch_mpu.sv
rtl/commit_mpu.sv
rtl/mpu.sv
test/mpu_checker.sv
test/tb_mpu.sv

/* rtl/commit_mpu.sv */
// Commit window: outstanding issue bitmap, in-order retirement and full level
`include "mpu_settings.svh"

module commit_mpu (
	input							clock,
	input							reset,
	input							issue_req,
	input	pkg_mpu::issue_no_t		issue_no,
	input							commit_valid,
	input	pkg_mpu::issue_no_t		commit_no,
	output	logic					commit_full
);
	import pkg_mpu::*;

	logic [`MPU_COMMIT_DEPTH-1:0]	pending;	// Issued, not yet committed
	issue_no_t						oldest;
	logic [`MPU_COUNT_W-1:0]		count;		// Issued, not yet retired
	logic							retire;

	// Oldest slot committed, step past it
	assign retire		= (count != '0) & ~pending[oldest];
	assign commit_full	= (count == `MPU_COMMIT_DEPTH);

	always_ff @(posedge clock) begin
		if (reset) begin
			pending	<= '0;
			oldest	<= '0;
			count	<= '0;
		end else begin
			if (issue_req)
				pending[issue_no] <= 1'b1;
			if (commit_valid && pending[commit_no])
				pending[commit_no] <= 1'b0;		// Stray numbers fall through

			if (retire)
				oldest <= oldest + 1'b1;

			case ({issue_req, retire})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

endmodule

/* rtl/dispatch_mpu.sv */
// Dispatcher FSM: commit gating, thread lookup, issue numbering and instruction streaming

module dispatch_mpu (
	input							clock,
	input							reset,
	input							run_req,
	input	pkg_mpu::thread_id_t	run_id,
	input							commit_full,
	input							lookup_hit,
	input	pkg_mpu::mem_addr_t		lookup_start,
	input	pkg_mpu::mem_addr_t		lookup_len,
	input	pkg_mpu::instr_t		mem_rdata,
	output	logic					lookup_req,
	output	pkg_mpu::thread_id_t	lookup_id,
	output	pkg_mpu::mem_addr_t		mem_raddr,
	output	logic					issue_req,
	output	pkg_mpu::issue_no_t		issue_no,
	output	logic					instr_valid,
	output	logic					instr_last,
	output	pkg_mpu::instr_t		instr,
	output	logic					busy,
	output	logic					bad_thread
);
	import pkg_mpu::*;

	dispatch_state_t	state;
	thread_id_t			held_id;		// Run waiting for room
	mem_addr_t			rd_addr;
	mem_addr_t			remain;			// Addresses still to read
	issue_no_t			issue_cnt;		// Next number to hand out

	//////////////////////////////////////////////////////////////////////
	// Lookup and read address
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			ST_IDLE:		lookup_req = run_req & ~commit_full;
			ST_WAIT_COMMIT:	lookup_req = ~commit_full;
			default:		lookup_req = 1'b0;
		endcase
	end

	assign lookup_id	= (state == ST_IDLE) ? run_id : held_id;
	assign mem_raddr	= (state == ST_LOOKUP) ? lookup_start : rd_addr;	// First word on the hit
	assign instr		= mem_rdata;

	// Covers the registered run and the word still leaving the RAM
	assign busy = (state != ST_IDLE) | run_req | instr_valid;

	//////////////////////////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state		<= ST_IDLE;
			remain		<= '0;
			issue_cnt	<= '0;
			issue_no	<= '0;
			issue_req	<= 1'b0;
			instr_valid	<= 1'b0;
			instr_last	<= 1'b0;
			bad_thread	<= 1'b0;
		end else begin
			issue_req	<= 1'b0;
			instr_valid	<= 1'b0;
			instr_last	<= 1'b0;
			bad_thread	<= 1'b0;
			case (state)
				ST_IDLE: begin
					if (run_req)
						state <= commit_full ? ST_WAIT_COMMIT : ST_LOOKUP;
				end
				ST_WAIT_COMMIT: begin
					if (!commit_full)
						state <= ST_LOOKUP;
				end
				ST_LOOKUP: begin
					if (lookup_hit) begin
						issue_req	<= 1'b1;
						issue_no	<= issue_cnt;
						issue_cnt	<= issue_cnt + 1'b1;
						instr_valid	<= 1'b1;			// Lines up with the RAM read
						instr_last	<= (lookup_len == 'd1);
						remain		<= lookup_len - 1'b1;
						state		<= (lookup_len == 'd1) ? ST_IDLE : ST_SEND;
					end else begin
						bad_thread	<= 1'b1;			// Number not consumed
						state		<= ST_IDLE;
					end
				end
				ST_SEND: begin
					instr_valid	<= 1'b1;
					instr_last	<= (remain == 'd1);
					remain		<= remain - 1'b1;
					if (remain == 'd1)
						state <= ST_IDLE;				// Last word still in flight
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == ST_IDLE && run_req)
			held_id <= run_id;
		if (state == ST_LOOKUP)
			rd_addr <= lookup_start + 1'b1;
		else if (state == ST_SEND)
			rd_addr <= rd_addr + 1'b1;
	end

endmodule

/* rtl/host_if_mpu.sv */
// Host command decoder with write pointer, open thread start, map writes, run request and wait
`include "mpu_settings.svh"

module host_if_mpu (
	input							clock,
	input							reset,
	input							cmd_valid,
	input	pkg_mpu::mpu_op_t		cmd_op,
	input	pkg_mpu::thread_id_t	cmd_thread_id,
	input	pkg_mpu::instr_t		cmd_instr,
	input							busy,
	output	logic					mem_we,
	output	pkg_mpu::mem_addr_t		mem_waddr,
	output	pkg_mpu::instr_t		mem_wdata,
	output	logic					map_we,
	output	pkg_mpu::thread_id_t	map_wid,
	output	pkg_mpu::mem_addr_t		map_start,
	output	pkg_mpu::mem_addr_t		map_len,
	output	logic					run_req,
	output	pkg_mpu::thread_id_t	run_id,
	output	logic					clear,
	output	logic					host_wait,
	output	logic					mem_full
);
	import pkg_mpu::*;

	mem_addr_t	wr_ptr;			// Next free word
	mem_addr_t	open_start;		// First word of the open thread
	logic		accept;

	// A full memory only drops loads, so end, run and clear still get through
	assign accept		= cmd_valid & ~busy;
	assign mem_full		= (wr_ptr == `MPU_MEM_DEPTH);
	assign host_wait	= busy | mem_full;

	assign mem_waddr	= wr_ptr;
	assign mem_wdata	= cmd_instr;
	assign map_wid		= cmd_thread_id;
	assign map_start	= open_start;
	assign map_len		= wr_ptr - open_start;		// Words since the last end

	always_comb begin
		mem_we	= 1'b0;
		map_we	= 1'b0;
		clear	= 1'b0;
		if (accept) begin
			case (cmd_op)
				OP_LOAD:	mem_we	= ~mem_full;
				OP_END:		map_we	= 1'b1;
				OP_CLEAR:	clear	= 1'b1;
				default:	;						// Run is registered below
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr		<= '0;
			open_start	<= '0;
			run_req		<= 1'b0;
		end else begin
			run_req <= accept & (cmd_op == OP_RUN);
			if (clear) begin
				wr_ptr		<= '0;
				open_start	<= '0;
			end else begin
				if (mem_we)
					wr_ptr <= wr_ptr + 1'b1;
				if (map_we)
					open_start <= wr_ptr;			// Next thread opens here
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			run_id <= cmd_thread_id;
	end

endmodule

/* rtl/map_table_mpu.sv */
// Thread map with start, length and valid per thread ID, and a registered lookup
`include "mpu_settings.svh"

module map_table_mpu (
	input							clock,
	input							reset,
	input							clear,
	input							map_we,
	input	pkg_mpu::thread_id_t	map_wid,
	input	pkg_mpu::mem_addr_t		map_start,
	input	pkg_mpu::mem_addr_t		map_len,
	input							lookup_req,
	input	pkg_mpu::thread_id_t	lookup_id,
	output	logic					lookup_hit,
	output	pkg_mpu::mem_addr_t		lookup_start,
	output	pkg_mpu::mem_addr_t		lookup_len
);
	import pkg_mpu::*;

	mem_addr_t	entry_start [`MPU_THREADS];
	mem_addr_t	entry_len [`MPU_THREADS];
	logic [`MPU_THREADS-1:0]	entry_valid;

	always_ff @(posedge clock) begin
		if (reset || clear)
			entry_valid <= '0;
		else if (map_we)
			entry_valid[map_wid] <= 1'b1;
	end

	// An end on a used ID replaces the old entry
	always_ff @(posedge clock) begin
		if (map_we) begin
			entry_start[map_wid]	<= map_start;
			entry_len[map_wid]		<= map_len;
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			lookup_hit <= 1'b0;
		else
			lookup_hit <= lookup_req & entry_valid[lookup_id]
				& (entry_len[lookup_id] != '0);		// Empty threads miss
	end

	always_ff @(posedge clock) begin
		lookup_start	<= entry_start[lookup_id];
		lookup_len		<= entry_len[lookup_id];
	end

endmodule

/* rtl/mpu.sv */
// MPU top level: host decoder, thread memory, thread map, dispatcher and commit window

module mpu (
	input							clock,
	input							reset,
	input							cmd_valid,
	input	pkg_mpu::mpu_op_t		cmd_op,
	input	pkg_mpu::thread_id_t	cmd_thread_id,
	input	pkg_mpu::instr_t		cmd_instr,
	input							commit_valid,
	input	pkg_mpu::issue_no_t		commit_no,
	output	logic					host_wait,
	output	logic					instr_valid,
	output	logic					instr_last,
	output	pkg_mpu::instr_t		instr,
	output	pkg_mpu::issue_no_t		issue_no,
	output	logic					bad_thread,
	output	logic					status_mem_full,
	output	logic					status_commit_full
);
	import pkg_mpu::*;

	// Host decoder to memory and map
	logic			mem_we;
	mem_addr_t		mem_waddr;
	instr_t			mem_wdata;
	logic			map_we;
	thread_id_t		map_wid;
	mem_addr_t		map_start;
	mem_addr_t		map_len;
	logic			clear;

	// Run path
	logic			run_req;
	thread_id_t		run_id;
	logic			busy;
	logic			lookup_req;
	thread_id_t		lookup_id;
	logic			lookup_hit;
	mem_addr_t		lookup_start;
	mem_addr_t		lookup_len;
	mem_addr_t		mem_raddr;
	instr_t			mem_rdata;

	// Commit window
	logic			issue_req;
	logic			commit_full;

	assign status_commit_full = commit_full;

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	host_if_mpu u_host_if (
		.clock			(clock),
		.reset			(reset),
		.cmd_valid		(cmd_valid),
		.cmd_op			(cmd_op),
		.cmd_thread_id	(cmd_thread_id),
		.cmd_instr		(cmd_instr),
		.busy			(busy),
		.mem_we			(mem_we),
		.mem_waddr		(mem_waddr),
		.mem_wdata		(mem_wdata),
		.map_we			(map_we),
		.map_wid		(map_wid),
		.map_start		(map_start),
		.map_len		(map_len),
		.run_req		(run_req),
		.run_id			(run_id),
		.clear			(clear),
		.host_wait		(host_wait),
		.mem_full		(status_mem_full)
	);

	//////////////////////////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////////////////////////

	thread_mem_mpu u_thread_mem (
		.clock			(clock),
		.mem_we			(mem_we),
		.mem_waddr		(mem_waddr),
		.mem_wdata		(mem_wdata),
		.mem_raddr		(mem_raddr),
		.mem_rdata		(mem_rdata)
	);

	map_table_mpu u_map_table (
		.clock			(clock),
		.reset			(reset),
		.clear			(clear),
		.map_we			(map_we),
		.map_wid		(map_wid),
		.map_start		(map_start),
		.map_len		(map_len),
		.lookup_req		(lookup_req),
		.lookup_id		(lookup_id),
		.lookup_hit		(lookup_hit),
		.lookup_start	(lookup_start),
		.lookup_len		(lookup_len)
	);

	dispatch_mpu u_dispatch (
		.clock			(clock),
		.reset			(reset),
		.run_req		(run_req),
		.run_id			(run_id),
		.commit_full	(commit_full),
		.lookup_hit		(lookup_hit),
		.lookup_start	(lookup_start),
		.lookup_len		(lookup_len),
		.mem_rdata		(mem_rdata),
		.lookup_req		(lookup_req),
		.lookup_id		(lookup_id),
		.mem_raddr		(mem_raddr),
		.issue_req		(issue_req),
		.issue_no		(issue_no),
		.instr_valid	(instr_valid),
		.instr_last		(instr_last),
		.instr			(instr),
		.busy			(busy),
		.bad_thread		(bad_thread)
	);

	//////////////////////////////////////////////////////////////////////
	// Results
	//////////////////////////////////////////////////////////////////////

	commit_mpu u_commit (
		.clock			(clock),
		.reset			(reset),
		.issue_req		(issue_req),
		.issue_no		(issue_no),
		.commit_valid	(commit_valid),
		.commit_no		(commit_no),
		.commit_full	(commit_full)
	);

endmodule

/* rtl/mpu_settings.svh */
// Size macros for thread memory, map table, instruction word and commit window
`ifndef MPU_SETTINGS_SVH
`define MPU_SETTINGS_SVH

// Instruction word
`define MPU_WORD_W			32

// Thread memory
`define MPU_MEM_DEPTH		64
`define MPU_MEM_AW			$clog2(`MPU_MEM_DEPTH)		// RAM index bits
`define MPU_ADDR_W			($clog2(`MPU_MEM_DEPTH) + 1)	// Holds a length of a full memory

// Thread map
`define MPU_THREADS			8
`define MPU_TID_W			$clog2(`MPU_THREADS)

// Commit window
`define MPU_COMMIT_DEPTH	4
`define MPU_ISSUE_W			$clog2(`MPU_COMMIT_DEPTH)
`define MPU_COUNT_W			($clog2(`MPU_COMMIT_DEPTH) + 1)	// Counts 0 to a full window

`endif

/* rtl/pkg_mpu.sv */
// Host opcode and dispatcher state enums, instruction, address, thread ID and issue number types
`include "mpu_settings.svh"

package pkg_mpu;

	// Host command opcodes
	typedef enum logic [2:0] {
		OP_NOP		= 3'd0,
		OP_LOAD		= 3'd1,		// Append one instruction word
		OP_END		= 3'd2,		// Close the open thread
		OP_RUN		= 3'd3,		// Issue a stored thread
		OP_CLEAR	= 3'd4		// Drop all threads
	} mpu_op_t;

	// Dispatcher FSM
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_COMMIT,			// Window full, hold the run
		ST_LOOKUP,				// Map answer arrives here
		ST_SEND					// Walking the read address
	} dispatch_state_t;

	typedef logic [`MPU_WORD_W-1:0]		instr_t;
	typedef logic [`MPU_ADDR_W-1:0]		mem_addr_t;		// Address and length
	typedef logic [`MPU_TID_W-1:0]		thread_id_t;
	typedef logic [`MPU_ISSUE_W-1:0]	issue_no_t;

endpackage

/* rtl/thread_mem_mpu.sv */
// Thread instruction RAM with one write port and one registered read port
`include "mpu_settings.svh"

module thread_mem_mpu (
	input							clock,
	input							mem_we,
	input	pkg_mpu::mem_addr_t		mem_waddr,
	input	pkg_mpu::instr_t		mem_wdata,
	input	pkg_mpu::mem_addr_t		mem_raddr,
	output	pkg_mpu::instr_t		mem_rdata
);
	import pkg_mpu::*;

	instr_t		mem [`MPU_MEM_DEPTH];

	logic [`MPU_MEM_AW-1:0]	waddr;
	logic [`MPU_MEM_AW-1:0]	raddr;

	// Top address bit only matters for lengths
	assign waddr = mem_waddr[`MPU_MEM_AW-1:0];
	assign raddr = mem_raddr[`MPU_MEM_AW-1:0];

	always_ff @(posedge clock) begin
		if (mem_we)
			mem[waddr] <= mem_wdata;
	end

	// Read data one cycle after the address
	always_ff @(posedge clock) begin
		mem_rdata <= mem[raddr];
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the MPU testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module tb_mpu -Mdir obj_dir -o tb_mpu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_mpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
	exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
	echo "Simulation log has no closing result line"
	exit 1
fi
exit 0

/* test/mpu_checker.sv */
// Concurrent assertions on the MPU tile stream, host wait level and commit window
module mpu_checker (
	input	clock,
	input	reset,
	input	instr_valid,
	input	instr_last,
	input	host_wait,
	input	issue_req,
	input	commit_full
);

	// Last beat belongs to a valid beat
	last_with_valid: assert property (@(posedge clock) disable iff (reset)
		instr_last |-> instr_valid)
		else $error("instr_last high without instr_valid");

	// Host is held off from the run until the stream ends
	stream_holds_host: assert property (@(posedge clock) disable iff (reset)
		instr_valid |-> host_wait && $past(host_wait))
		else $error("instr_valid high while host wait is low");

	// No issue beyond the window
	issue_has_room: assert property (@(posedge clock) disable iff (reset)
		issue_req |-> !commit_full)
		else $error("thread issued while the commit window was full");

endmodule

bind mpu mpu_checker checker_i (
	.clock			(clock),
	.reset			(reset),
	.instr_valid	(instr_valid),
	.instr_last		(instr_last),
	.host_wait		(host_wait),
	.issue_req		(issue_req),
	.commit_full	(commit_full)
);

/* test/tb_mpu.sv */
// MPU testbench with random host and commit stimulus, a reference model and output checks
`include "mpu_settings.svh"

module tb_mpu;
	import pkg_mpu::*;

	localparam int TIMEOUT = 60;

	logic		clock;
	logic		reset;
	logic		cmd_valid;
	mpu_op_t	cmd_op;
	thread_id_t	cmd_thread_id;
	instr_t		cmd_instr;
	logic		commit_valid;
	issue_no_t	commit_no;
	logic		host_wait;
	logic		instr_valid;
	logic		instr_last;
	instr_t		instr;
	issue_no_t	issue_no;
	logic		bad_thread;
	logic		status_mem_full;
	logic		status_commit_full;

	// Reference model
	instr_t		model_mem [`MPU_MEM_DEPTH];
	int			model_start [`MPU_THREADS];
	int			model_len [`MPU_THREADS];
	bit			model_valid [`MPU_THREADS];
	bit			model_pending [`MPU_COMMIT_DEPTH];
	int			model_wptr;
	int			model_open;		// Start of the open thread
	int			next_no;
	int			model_oldest;
	int			model_count;	// Issued, not retired
	int			errors;
	int			timeouts;
	integer		seed;

	mpu dut_i (
		.clock				(clock),
		.reset				(reset),
		.cmd_valid			(cmd_valid),
		.cmd_op				(cmd_op),
		.cmd_thread_id		(cmd_thread_id),
		.cmd_instr			(cmd_instr),
		.commit_valid		(commit_valid),
		.commit_no			(commit_no),
		.host_wait			(host_wait),
		.instr_valid		(instr_valid),
		.instr_last			(instr_last),
		.instr				(instr),
		.issue_no			(issue_no),
		.bad_thread			(bad_thread),
		.status_mem_full	(status_mem_full),
		.status_commit_full	(status_commit_full)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		$display("FAILED %s expected %h got %h", name, exp, got);
		errors++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Host and tile drivers
	//////////////////////////////////////////////////////////////////////

	// A full memory only blocks loads
	task automatic wait_ready(input mpu_op_t op);
		int n;
		n = 0;
		@(negedge clock);
		while (host_wait && !(status_mem_full && op != OP_LOAD) && n < TIMEOUT) begin
			@(negedge clock);
			n++;
		end
		if (host_wait && !(status_mem_full && op != OP_LOAD)) begin
			$display("Timeout: host wait stayed high before a command");
			timeouts++;
		end
	endtask

	task automatic drive_cmd(input mpu_op_t op, input thread_id_t id, input instr_t data);
		wait_ready(op);
		@(posedge clock);
		cmd_valid		<= 1'b1;
		cmd_op			<= op;
		cmd_thread_id	<= id;
		cmd_instr		<= data;
		@(posedge clock);
		cmd_valid		<= 1'b0;
		cmd_op			<= OP_NOP;
	endtask

	task automatic load_thread(input thread_id_t id, input int len);
		instr_t word;
		for (int i = 0; i < len; i++) begin
			word = $random(seed);
			drive_cmd(OP_LOAD, id, word);
			model_mem[model_wptr] = word;
			model_wptr++;
		end
		drive_cmd(OP_END, id, '0);
		model_valid[id]	= 1'b1;
		model_start[id]	= model_open;
		model_len[id]	= model_wptr - model_open;
		model_open		= model_wptr;
	endtask

	task automatic clear_all();
		drive_cmd(OP_CLEAR, '0, '0);
		model_wptr = 0;
		model_open = 0;
		for (int i = 0; i < `MPU_THREADS; i++)
			model_valid[i] = 1'b0;
	endtask

	// Model retires in order right away, the DUT one step per cycle
	task automatic commit_number(input int no);
		@(posedge clock);
		commit_valid	<= 1'b1;
		commit_no		<= issue_no_t'(no);
		@(posedge clock);
		commit_valid	<= 1'b0;
		model_pending[no] = 1'b0;
		while (model_count > 0 && !model_pending[model_oldest]) begin
			model_oldest = (model_oldest + 1) % `MPU_COMMIT_DEPTH;
			model_count--;
		end
	endtask

	task automatic check_full();
		bit exp;
		exp = (model_count == `MPU_COMMIT_DEPTH);
		repeat (6) @(posedge clock);
		@(negedge clock);
		if (status_commit_full !== exp)
			report_mismatch("status_commit_full", exp, status_commit_full);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run response check, called at the edge after the run command
	//////////////////////////////////////////////////////////////////////

	task automatic check_run(input thread_id_t id, input bit timed);
		int cycles;
		int len;
		bit hit;
		len = model_len[id];
		hit = model_valid[id] && len != 0;
		cycles = 1;
		@(negedge clock);
		while (!instr_valid && !bad_thread && cycles < TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!instr_valid && !bad_thread) begin
			$display("Timeout: run of thread %0d gave no stream and no bad_thread", id);
			timeouts++;
			return;
		end
		if (timed && cycles != 3) begin
			$display("Run response came %0d cycles after the command instead of 3", cycles);
			errors++;
		end
		if (!hit) begin
			if (bad_thread !== 1'b1)
				report_mismatch("bad_thread", 1, bad_thread);
			@(negedge clock);
			if (bad_thread !== 1'b0 || instr_valid !== 1'b0) begin
				$display("Run of a missing thread did more than one bad_thread pulse");
				errors++;
			end
			return;
		end
		for (int i = 0; i < len; i++) begin
			if (i > 0)
				@(negedge clock);
			if (instr_valid !== 1'b1)
				report_mismatch("instr_valid", 1, instr_valid);
			if (instr !== model_mem[model_start[id] + i])
				report_mismatch("instr", model_mem[model_start[id] + i], instr);
			if (issue_no !== issue_no_t'(next_no))
				report_mismatch("issue_no", next_no, issue_no);
			if (instr_last !== (i == len - 1))
				report_mismatch("instr_last", i == len - 1, instr_last);
			if (bad_thread !== 1'b0)
				report_mismatch("bad_thread", 0, bad_thread);
		end
		@(negedge clock);
		if (instr_valid !== 1'b0)
			report_mismatch("instr_valid", 0, instr_valid);
		model_pending[next_no] = 1'b1;
		model_count++;
		next_no = (next_no + 1) % `MPU_COMMIT_DEPTH;
	endtask

	task automatic run_thread(input thread_id_t id);
		if (model_count == `MPU_COMMIT_DEPTH) begin
			commit_number(model_oldest);	// Free the oldest number first
			check_full();
		end
		drive_cmd(OP_RUN, id, '0);
		check_run(id, 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		thread_id_t id;
		int n;
		seed			= 32'h1ed38ada;
		errors			= 0;
		timeouts		= 0;
		model_wptr		= 0;
		model_open		= 0;
		next_no			= 0;
		model_oldest	= 0;
		model_count		= 0;
		for (int i = 0; i < `MPU_THREADS; i++)
			model_valid[i] = 1'b0;
		for (int i = 0; i < `MPU_COMMIT_DEPTH; i++)
			model_pending[i] = 1'b0;
		reset			= 1'b1;
		cmd_valid		= 1'b0;
		cmd_op			= OP_NOP;
		cmd_thread_id	= '0;
		cmd_instr		= '0;
		commit_valid	= 1'b0;
		commit_no		= '0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		if (host_wait !== 1'b0)
			report_mismatch("host_wait", 0, host_wait);
		if (instr_valid !== 1'b0)
			report_mismatch("instr_valid", 0, instr_valid);
		if (instr_last !== 1'b0)
			report_mismatch("instr_last", 0, instr_last);
		if (bad_thread !== 1'b0)
			report_mismatch("bad_thread", 0, bad_thread);
		if (status_commit_full !== 1'b0)
			report_mismatch("status_commit_full", 0, status_commit_full);

		// Streams, issue numbers, then a full window
		load_thread(3'd0, 5);
		load_thread(3'd1, 1);
		run_thread(3'd0);
		run_thread(3'd1);
		run_thread(3'd0);
		run_thread(3'd1);
		check_full();
		drive_cmd(OP_RUN, 3'd0, '0);
		for (int i = 0; i < 8; i++) begin
			@(negedge clock);
			if (instr_valid || bad_thread) begin
				$display("Run went ahead while the commit window was full");
				errors++;
			end
		end
		commit_number(model_oldest);
		check_run(3'd0, 1'b0);
		check_full();

		// Random and stray commits
		for (int i = 0; i < 8; i++) begin
			commit_number($unsigned($random(seed)) % `MPU_COMMIT_DEPTH);
			check_full();
		end

		// Undefined, empty and cleared threads
		run_thread(3'd7);
		load_thread(3'd3, 0);
		run_thread(3'd3);
		clear_all();
		run_thread(3'd0);
		load_thread(3'd2, 3);
		run_thread(3'd2);

		// Fill the memory, then clear it
		clear_all();
		while (model_wptr < `MPU_MEM_DEPTH) begin
			drive_cmd(OP_LOAD, '0, $random(seed));
			model_wptr++;
		end
		@(negedge clock);
		if (status_mem_full !== 1'b1)
			report_mismatch("status_mem_full", 1, status_mem_full);
		if (host_wait !== 1'b1)
			report_mismatch("host_wait", 1, host_wait);
		clear_all();
		@(negedge clock);
		if (status_mem_full !== 1'b0)
			report_mismatch("status_mem_full", 0, status_mem_full);
		if (host_wait !== 1'b0)
			report_mismatch("host_wait", 0, host_wait);
		load_thread(3'd5, 4);
		run_thread(3'd5);

		// Random loads, runs and commits
		for (int i = 0; i < 24; i++) begin
			id = thread_id_t'($random(seed));
			if (model_wptr > 48)
				clear_all();
			if (($random(seed) & 1) == 1)
				load_thread(id, $unsigned($random(seed)) % 6);
			run_thread(id);
			n = $unsigned($random(seed)) % 3;
			repeat (n)
				commit_number($unsigned($random(seed)) % `MPU_COMMIT_DEPTH);
			check_full();
		end

		$display("Error count: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
